//--- source/tmc_pkg.sv
package tmc_pkg;

	localparam int NUART = 4;            // Driver channels
	localparam int CH_BITS = 2;
	localparam int BIT_CLKS = 16;        // Clocks per UART bit
	localparam int BIT_CNT_BITS = $clog2(BIT_CLKS);

	localparam int TURN_BITS = 2;        // Request end to line release
	localparam int GUARD_BITS = 8;       // Response to idle
	localparam int RX_TIMEOUT_BITS = 120; // Whole reply window

	localparam int TURN_CLKS = TURN_BITS * BIT_CLKS;
	localparam int GUARD_CLKS = GUARD_BITS * BIT_CLKS;
	localparam int RX_TIMEOUT_CLKS = RX_TIMEOUT_BITS * BIT_CLKS;
	localparam int TIMER_BITS = $clog2(RX_TIMEOUT_CLKS);

	localparam logic [7:0] SYNC_BYTE = 8'h05;
	localparam logic [7:0] MASTER_ADDR = 8'hff; // Address field of every reply
	localparam logic [7:0] CRC_POLY = 8'h07;

	// Codes 0 and 3 are rejected as BAD_CMD
	typedef enum logic [1:0] {
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2
	} tmc_op_e;

	typedef enum logic [2:0] {
		ST_OK          = 3'd0,
		ST_TIMEOUT     = 3'd1,
		ST_SYNC        = 3'd2,
		ST_MASTER_ADDR = 3'd3,
		ST_REGISTER    = 3'd4,
		ST_CRC         = 3'd5,
		ST_BAD_CMD     = 3'd6
	} tmc_status_e;

	typedef struct packed {
		tmc_op_e            op;
		logic [CH_BITS-1:0] channel;
		logic [7:0]         slave;
		logic [6:0]         register;
		logic [31:0]        data;     // Write payload, ignored for reads
	} tmc_cmd_t;

	typedef struct packed {
		tmc_status_e status;
		logic [31:0] data;
	} tmc_rsp_t;

endpackage

//--- source/uart_byte.sv
`timescale 1ns/1ps

module uart_byte (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_byte,
	output logic       tx_busy,
	output logic       tx_line,
	input  logic       rx_line,
	output logic       rx_valid,
	output logic [7:0] rx_byte
);
	import tmc_pkg::*;

	logic [8:0] tx_shift;              // Stop bit above the data bits
	logic [3:0] tx_bits;               // Bits left after the current one
	logic [BIT_CNT_BITS-1:0] tx_cnt;

	logic [1:0] rx_sync;
	logic rx_prev;
	logic rx_active;
	logic [3:0] rx_bits;               // 0 start, 1 to 8 data, 9 stop
	logic [BIT_CNT_BITS-1:0] rx_cnt;

	// Transmitter
	always_ff @(posedge clk) begin
		if (reset) begin
			tx_busy <= 1'b0;
			tx_line <= 1'b1;
			tx_bits <= 4'd0;
			tx_cnt <= '0;
		end else if (tx_start && !tx_busy) begin
			tx_busy <= 1'b1;
			tx_line <= 1'b0;              // Start bit
			tx_shift <= {1'b1, tx_byte};
			tx_bits <= 4'd9;
			tx_cnt <= BIT_CNT_BITS'(BIT_CLKS - 1);
		end else if (tx_busy) begin
			if (tx_cnt != 0) begin
				tx_cnt <= tx_cnt - 1'b1;
			end else if (tx_bits != 0) begin
				tx_line <= tx_shift[0];
				tx_shift <= {1'b1, tx_shift[8:1]};
				tx_bits <= tx_bits - 1'b1;
				tx_cnt <= BIT_CNT_BITS'(BIT_CLKS - 1);
			end else begin
				tx_busy <= 1'b0;          // Stop bit has run its full time
			end
		end
	end

	// Receiver
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			rx_bits <= 4'd0;
			rx_cnt <= '0;
		end else begin
			rx_sync <= {rx_sync[0], rx_line};
			rx_prev <= rx_sync[1];
			rx_valid <= 1'b0;
			if (!rx_active) begin
				if (rx_prev && !rx_sync[1]) begin
					rx_active <= 1'b1;    // Falling edge of a start bit
					rx_bits <= 4'd0;
					rx_cnt <= BIT_CNT_BITS'(BIT_CLKS / 2 - 1);
				end
			end else if (rx_cnt != 0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= BIT_CNT_BITS'(BIT_CLKS - 1);
				if (rx_bits == 4'd0) begin
					if (rx_sync[1])
						rx_active <= 1'b0; // Glitch, not a start bit
					else
						rx_bits <= 4'd1;
				end else if (rx_bits == 4'd9) begin
					rx_active <= 1'b0;
					rx_valid <= rx_sync[1]; // Framing errors are dropped
				end else begin
					rx_byte <= {rx_sync[1], rx_byte[7:1]};
					rx_bits <= rx_bits + 1'b1;
				end
			end
		end
	end

endmodule

//--- source/tmc_crc8.sv
`timescale 1ns/1ps

module tmc_crc8 (
	input  logic       clk,
	input  logic       reset,
	input  logic       crc_clear,
	input  logic       crc_feed,
	input  logic [7:0] crc_byte,
	output logic [7:0] crc_value
);
	import tmc_pkg::*;

	logic [6:0] crc_shift;             // Bits of the byte still to go
	logic [2:0] crc_cnt;

	function automatic logic [7:0] crc_step(input logic [7:0] crc, input logic din);
		crc_step = {crc[6:0], 1'b0} ^ ((crc[7] ^ din) ? CRC_POLY : 8'h00);
	endfunction

	// First bit goes in on the feed edge, so the value settles 8 cycles later
	always_ff @(posedge clk) begin
		if (reset || crc_clear) begin
			crc_value <= 8'h00;
			crc_cnt <= 3'd0;
		end else if (crc_feed) begin
			crc_value <= crc_step(crc_value, crc_byte[0]);
			crc_shift <= crc_byte[7:1];
			crc_cnt <= 3'd7;
		end else if (crc_cnt != 0) begin
			crc_value <= crc_step(crc_value, crc_shift[0]);
			crc_shift <= {1'b0, crc_shift[6:1]};
			crc_cnt <= crc_cnt - 1'b1;
		end
	end

endmodule

//--- source/tmc_uart_master.sv
`timescale 1ns/1ps

module tmc_uart_master (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cmd_valid,
	input  tmc_pkg::tmc_cmd_t         cmd,
	output logic                      busy,
	output logic                      rsp_valid,
	output tmc_pkg::tmc_rsp_t         rsp,
	input  logic [tmc_pkg::NUART-1:0] uart_in,
	output logic [tmc_pkg::NUART-1:0] uart_out,
	output logic [tmc_pkg::NUART-1:0] uart_en,
	output logic                      tx_start,
	output logic [7:0]                tx_byte,
	input  logic                      tx_busy,
	input  logic                      tx_line,
	output logic                      rx_line,
	input  logic                      rx_valid,
	input  logic [7:0]                rx_byte,
	output logic                      crc_clear,
	output logic                      crc_feed,
	output logic [7:0]                crc_byte,
	input  logic [7:0]                crc_value
);
	import tmc_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_SEND,
		S_TX_WAIT,
		S_TURN,
		S_RECV,
		S_RESP,
		S_GUARD
	} state_e;

	state_e state;
	tmc_status_e status;
	tmc_status_e rx_err;
	logic [CH_BITS-1:0] ch;
	logic is_write;
	logic [7:0] slave;
	logic [6:0] register;
	logic [31:0] data;
	logic [2:0] idx;                   // Byte index, shared by request and reply
	logic [TIMER_BITS-1:0] timer;
	logic line_en;                     // Master drives the selected line
	logic [7:0] next_byte;
	logic last_byte;

	always_comb begin
		case (idx)
			3'd0: next_byte = SYNC_BYTE;
			3'd1: next_byte = slave;
			3'd2: next_byte = {is_write, register};
			3'd3: next_byte = is_write ? data[31:24] : crc_value;
			3'd4: next_byte = data[23:16];
			3'd5: next_byte = data[15:8];
			3'd6: next_byte = data[7:0];
			default: next_byte = crc_value;
		endcase
	end

	assign last_byte = (idx == (is_write ? 3'd7 : 3'd3));

	// Reply check for the byte now on rx_byte
	always_comb begin
		rx_err = ST_OK;
		case (idx)
			3'd0: if (rx_byte[3:0] != SYNC_BYTE[3:0]) rx_err = ST_SYNC;
			3'd1: if (rx_byte != MASTER_ADDR) rx_err = ST_MASTER_ADDR;
			3'd2: if (rx_byte != {1'b0, register}) rx_err = ST_REGISTER;
			3'd7: if (rx_byte != crc_value) rx_err = ST_CRC;
			default: rx_err = ST_OK;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			status <= ST_OK;
			busy <= 1'b0;
			rsp_valid <= 1'b0;
			tx_start <= 1'b0;
			crc_clear <= 1'b0;
			crc_feed <= 1'b0;
			line_en <= 1'b1;
			is_write <= 1'b0;
			ch <= '0;
			idx <= 3'd0;
			timer <= '0;
		end else begin
			rsp_valid <= 1'b0;
			tx_start <= 1'b0;
			crc_clear <= 1'b0;
			crc_feed <= 1'b0;
			if (timer != 0)
				timer <= timer - 1'b1;   // Loads below take priority

			case (state)
				S_IDLE: if (cmd_valid) begin
					busy <= 1'b1;
					ch <= cmd.channel;
					is_write <= (cmd.op == OP_WRITE);
					slave <= cmd.slave;
					register <= cmd.register;
					idx <= 3'd0;
					if (cmd.op == OP_WRITE || cmd.op == OP_READ) begin
						data <= cmd.data;
						status <= ST_OK;
						crc_clear <= 1'b1;
						state <= S_SEND;
					end else begin
						data <= '0;
						status <= ST_BAD_CMD; // No line activity
						state <= S_RESP;
					end
				end
				S_SEND: if (!tx_busy && !tx_start) begin
					tx_start <= 1'b1;
					tx_byte <= next_byte;
					crc_byte <= next_byte;
					crc_feed <= !last_byte;   // CRC byte is not fed back
					idx <= idx + 1'b1;
					if (last_byte)
						state <= S_TX_WAIT;
				end
				S_TX_WAIT: if (!tx_busy && !tx_start) begin
					if (is_write) begin
						data <= '0;
						state <= S_RESP;
					end else begin
						timer <= TIMER_BITS'(TURN_CLKS - 1);
						state <= S_TURN;
					end
				end
				S_TURN: if (timer == 0) begin
					line_en <= 1'b0;          // Hand the line to the driver chip
					crc_clear <= 1'b1;
					idx <= 3'd0;
					data <= '0;
					timer <= TIMER_BITS'(RX_TIMEOUT_CLKS - 1);
					state <= S_RECV;
				end
				S_RECV: if (rx_valid) begin
					idx <= idx + 1'b1;
					crc_byte <= rx_byte;
					crc_feed <= (idx != 3'd7);
					if (status == ST_OK)
						status <= rx_err;     // First failure wins
					if (idx >= 3'd3 && idx <= 3'd6)
						data <= {data[23:0], rx_byte};
					if (idx == 3'd7)
						state <= S_RESP;
				end else if (timer == 0) begin
					if (status == ST_OK)
						status <= ST_TIMEOUT;
					state <= S_RESP;
				end
				S_RESP: begin
					rsp_valid <= 1'b1;
					rsp.status <= status;
					rsp.data <= data;
					line_en <= 1'b1;
					timer <= (status == ST_BAD_CMD) ? '0 : TIMER_BITS'(GUARD_CLKS - 1);
					state <= S_GUARD;
				end
				S_GUARD: if (timer == 0) begin
					busy <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Channel mux, idle channels are driven high
	always_comb begin
		for (int i = 0; i < NUART; i++) begin
			uart_out[i] = (CH_BITS'(i) == ch) ? tx_line : 1'b1;
			uart_en[i] = (CH_BITS'(i) == ch) ? line_en : 1'b1;
		end
	end

	assign rx_line = line_en ? 1'b1 : uart_in[ch]; // Blocks own echo

endmodule

//--- source/tmc_uart_top.sv
`timescale 1ns/1ps

module tmc_uart_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      cmd_valid,
	input  tmc_pkg::tmc_cmd_t         cmd,
	output logic                      busy,
	output logic                      rsp_valid,
	output tmc_pkg::tmc_rsp_t         rsp,
	input  logic [tmc_pkg::NUART-1:0] uart_in,
	output logic [tmc_pkg::NUART-1:0] uart_out,
	output logic [tmc_pkg::NUART-1:0] uart_en
);

	logic       tx_start;
	logic [7:0] tx_byte;
	logic       tx_busy;
	logic       tx_line;
	logic       rx_line;
	logic       rx_valid;
	logic [7:0] rx_byte;
	logic       crc_clear;
	logic       crc_feed;
	logic [7:0] crc_byte;
	logic [7:0] crc_value;

	tmc_uart_master master_i (
		.clk(clk), .reset(reset),
		.cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.uart_in(uart_in), .uart_out(uart_out), .uart_en(uart_en),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy), .tx_line(tx_line),
		.rx_line(rx_line), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.crc_clear(crc_clear), .crc_feed(crc_feed), .crc_byte(crc_byte),
		.crc_value(crc_value)
	);

	uart_byte uart_i (
		.clk(clk), .reset(reset),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy), .tx_line(tx_line),
		.rx_line(rx_line), .rx_valid(rx_valid), .rx_byte(rx_byte)
	);

	tmc_crc8 crc_i (
		.clk(clk), .reset(reset),
		.crc_clear(crc_clear), .crc_feed(crc_feed), .crc_byte(crc_byte),
		.crc_value(crc_value)
	);

endmodule

//--- test/tmc_uart_chk.sv
`timescale 1ns/1ps

module tmc_uart_chk (
	input logic                      clk,
	input logic                      reset,
	input logic                      cmd_valid,
	input logic                      busy,
	input logic                      rsp_valid,
	input logic [tmc_pkg::NUART-1:0] uart_out,
	input logic [tmc_pkg::NUART-1:0] uart_en
);
	import tmc_pkg::*;

	one_listener: assert property (@(posedge clk) disable iff (reset)
		$countones(~uart_en) <= 1)
		else $error("more than one channel released");

	idle_lines: assert property (@(posedge clk) disable iff (reset)
		!busy |-> (&uart_en && &uart_out))
		else $error("line not idle while not busy");

	rsp_when_busy: assert property (@(posedge clk) disable iff (reset)
		rsp_valid |-> busy)
		else $error("response outside a transaction");

	no_cmd_when_busy: assert property (@(posedge clk) disable iff (reset)
		cmd_valid |-> !busy)
		else $error("command given while busy");

endmodule

bind tmc_uart_top tmc_uart_chk chk_i (.*);

//--- test/tb_tmc_uart.sv
`timescale 1ns/1ps

module tb_tmc_uart;
	import tmc_pkg::*;

	localparam int N_TESTS = 19;
	localparam int MAX_CYCLES = N_TESTS * 250 * BIT_CLKS;

	typedef enum int {F_NONE, F_SILENT, F_SYNC, F_ADDR, F_REG, F_CRC} fault_e;

	typedef struct packed {
		logic [CH_BITS-1:0] ch;
		logic [3:0]         len;
		logic [63:0]        bytes;     // Byte 0 in the top bits
	} frame_t;

	logic clk = 1'b0;
	logic reset;
	logic cmd_valid;
	tmc_cmd_t cmd;
	logic busy;
	logic rsp_valid;
	tmc_rsp_t rsp;
	logic [NUART-1:0] uart_in;
	logic [NUART-1:0] uart_out;
	logic [NUART-1:0] uart_en;

	logic [NUART-1:0] allowed;         // Channels that may move now
	fault_e fault;
	logic [31:0] reply_data;
	tmc_rsp_t exp_rsp_q[$];
	frame_t exp_frame_q[$];
	int rsp_errs = 0;
	int frame_errs = 0;
	int line_errs = 0;
	int n_cmd = 0;
	int n_rsp = 0;
	int cycles = 0;
	int guard_left = 0;                // Cycles until busy must fall

	tmc_uart_top dut_i (
		.clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
		.rsp_valid(rsp_valid), .rsp(rsp),
		.uart_in(uart_in), .uart_out(uart_out), .uart_en(uart_en)
	);

	always #20 clk = ~clk;

	// TMC CRC-8, each byte fed LSB first
	function automatic logic [7:0] frame_crc(input logic [63:0] bytes, input int n);
		logic [7:0] crc;
		logic [7:0] b;
		crc = 8'h00;
		for (int i = 0; i < n; i++) begin
			b = bytes[63 - 8 * i -: 8];
			for (int k = 0; k < 8; k++) begin
				if (crc[7] ^ b[k])
					crc = {crc[6:0], 1'b0} ^ CRC_POLY;
				else
					crc = {crc[6:0], 1'b0};
			end
		end
		return crc;
	endfunction

	function automatic frame_t build_frame(input tmc_cmd_t c);
		frame_t f;
		f.ch = c.channel;
		if (c.op == OP_WRITE) begin
			f.len = 4'd8;
			f.bytes = {SYNC_BYTE, c.slave, 1'b1, c.register, c.data, 8'h00};
			f.bytes[7:0] = frame_crc(f.bytes, 7);
		end else begin
			f.len = 4'd4;
			f.bytes = {SYNC_BYTE, c.slave, 1'b0, c.register, 40'h0};
			f.bytes[39:32] = frame_crc(f.bytes, 3);
		end
		return f;
	endfunction

	function automatic tmc_rsp_t expect_rsp(input tmc_cmd_t c, input fault_e f,
			input logic [31:0] d);
		tmc_rsp_t r;
		r.data = d;
		case (f)
			F_SILENT: r.status = ST_TIMEOUT;
			F_SYNC:   r.status = ST_SYNC;
			F_ADDR:   r.status = ST_MASTER_ADDR;
			F_REG:    r.status = ST_REGISTER;
			F_CRC:    r.status = ST_CRC;
			default:  r.status = ST_OK;
		endcase
		if (f == F_SILENT)
			r.data = '0;                  // Nothing received
		if (c.op != OP_READ) begin
			r.status = (c.op == OP_WRITE) ? ST_OK : ST_BAD_CMD;
			r.data = '0;
		end
		return r;
	endfunction

	function automatic tmc_cmd_t rand_cmd(input tmc_op_e op);
		tmc_cmd_t c;
		c.op = op;
		c.channel = CH_BITS'($urandom_range(NUART - 1, 0));
		c.slave = 8'($urandom);
		c.register = 7'($urandom);
		c.data = $urandom;
		return c;
	endfunction

	task automatic check_rsp(input tmc_rsp_t got, input tmc_rsp_t exp);
		if (got !== exp) begin
			$display("ERR %0t: response %s %h, expected %s %h", $time,
				got.status.name(), got.data, exp.status.name(), exp.data);
			rsp_errs++;
		end
	endtask

	task automatic check_frame(input frame_t got, input frame_t exp);
		if (got !== exp) begin
			$display("ERR %0t: frame ch %0d len %0d %h, expected ch %0d len %0d %h",
				$time, got.ch, got.len, got.bytes, exp.ch, exp.len, exp.bytes);
			frame_errs++;
		end
	endtask

	// Called at the sample where the start bit was seen
	task automatic read_byte(input int c, output logic [7:0] b);
		repeat (BIT_CLKS / 2) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge clk);
			b[i] = uart_out[c];
		end
		repeat (BIT_CLKS) @(negedge clk);
		if (uart_out[c] !== 1'b1) begin
			$display("ERR %0t: no stop bit on channel %0d", $time, c);
			frame_errs++;
		end
	endtask

	task automatic send_byte(input int c, input logic [7:0] b);
		logic [9:0] w;
		logic [NUART-1:0] line;
		w = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			line = '1;
			line[c] = w[i];
			@(posedge clk);
			uart_in <= line;
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	task automatic run_cmd(input tmc_cmd_t c, input fault_e f);
		logic op_ok;
		op_ok = (c.op == OP_WRITE || c.op == OP_READ);
		@(posedge clk);
		fault = f;
		reply_data = $urandom;
		allowed = op_ok ? (NUART'(1) << c.channel) : '0;
		exp_rsp_q.push_back(expect_rsp(c, f, reply_data));
		if (op_ok)
			exp_frame_q.push_back(build_frame(c));
		cmd_valid <= 1'b1;
		cmd <= c;
		@(posedge clk);
		cmd_valid <= 1'b0;
		n_cmd++;
		@(negedge clk);
		if (busy !== 1'b1) begin
			$display("ERR %0t: busy did not rise after the command", $time);
			line_errs++;
		end
		if (!op_ok) begin
			@(negedge clk);
			if (rsp_valid !== 1'b1) begin
				$display("ERR %0t: no BAD_CMD response two cycles after the command", $time);
				rsp_errs++;
			end
		end
		while (busy)
			@(negedge clk);
	endtask

	// Driver chip model, one transaction at a time across all channels
	initial begin
		int c;
		frame_t got;
		logic [63:0] reply;
		logic [7:0] b;
		logic extra;
		uart_in = '1;
		forever begin
			@(negedge clk);
			if (!reset && (uart_en & ~uart_out) != '0) begin
				for (int i = NUART - 1; i >= 0; i--)
					if (uart_en[i] && !uart_out[i])
						c = i;
				got = '0;
				got.ch = CH_BITS'(c);
				got.len = 4'd4;
				for (int n = 0; n < int'(got.len); n++) begin
					if (n > 0)
						do @(negedge clk); while (uart_out[c]); // Next start bit
					read_byte(c, b);
					got.bytes[63 - 8 * n -: 8] = b;
					if (n == 2 && b[7])
						got.len = 4'd8;       // Write request
				end
				if (exp_frame_q.size() == 0) begin
					$display("A frame arrived on channel %0d with no command pending", c);
					frame_errs++;
				end else begin
					check_frame(got, exp_frame_q.pop_front());
				end
				if (got.len == 4'd4 && fault != F_SILENT) begin
					extra = 1'b0;
					do begin
						@(negedge clk);
						extra = extra | (uart_en[c] && !uart_out[c]);
					end while (uart_en[c]);
					if (extra) begin
						$display("The read request on channel %0d ran past four bytes", c);
						frame_errs++;
					end
					repeat (2 * BIT_CLKS) @(posedge clk);
					reply = {SYNC_BYTE, MASTER_ADDR, 1'b0, got.bytes[46:40], reply_data, 8'h00};
					if (fault == F_SYNC)
						reply[63:56] = 8'h0a;
					if (fault == F_ADDR)
						reply[55:48] = 8'hfe;
					if (fault == F_REG)
						reply[40] = ~reply[40];
					reply[7:0] = frame_crc(reply, 7) ^ ((fault == F_CRC) ? 8'h01 : 8'h00);
					for (int n = 0; n < 8; n++)
						send_byte(c, reply[63 - 8 * n -: 8]);
				end
			end
		end
	end

	// Response compare and guard time
	always @(negedge clk) begin
		tmc_rsp_t exp_rsp;
		if (guard_left > 0) begin
			guard_left--;
			if (busy !== (guard_left != 0)) begin
				$display("ERR %0t: busy %b, expected %b in the guard time", $time,
					busy, guard_left != 0);
				line_errs++;
				guard_left = 0;
			end
		end
		if (rsp_valid) begin
			n_rsp++;
			if (exp_rsp_q.size() == 0) begin
				$display("A response arrived with no command pending");
				rsp_errs++;
			end else begin
				exp_rsp = exp_rsp_q.pop_front();
				check_rsp(rsp, exp_rsp);
				guard_left = (exp_rsp.status == ST_BAD_CMD) ? 1 : GUARD_BITS * BIT_CLKS;
			end
		end
	end

	// Line ownership
	always @(negedge clk) begin
		if (!reset) begin
			for (int c = 0; c < NUART; c++) begin
				if (!allowed[c] && (uart_out[c] !== 1'b1 || uart_en[c] !== 1'b1)) begin
					$display("ERR %0t: activity on channel %0d", $time, c);
					line_errs++;
				end
			end
			if ($countones(~uart_en) > 1 || (!busy && (uart_en != '1 || uart_out != '1))
					|| (rsp_valid && !busy)) begin
				$display("ERR %0t: line or busy state out of order", $time);
				line_errs++;
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > MAX_CYCLES) begin
			$display("The run hung and was stopped after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		tmc_cmd_t c;
		void'($urandom(32'h53c83dad));
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		allowed = '0;
		fault = F_NONE;
		reply_data = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		repeat (2) run_cmd(rand_cmd(OP_WRITE), F_NONE);
		repeat (2) run_cmd(rand_cmd(OP_READ), F_NONE);
		run_cmd(rand_cmd(OP_READ), F_SILENT);
		run_cmd(rand_cmd(OP_READ), F_SYNC);
		run_cmd(rand_cmd(OP_READ), F_ADDR);
		run_cmd(rand_cmd(OP_READ), F_REG);
		run_cmd(rand_cmd(OP_READ), F_CRC);
		run_cmd(rand_cmd(tmc_op_e'(2'd0)), F_NONE);
		run_cmd(rand_cmd(tmc_op_e'(2'd3)), F_NONE);
		for (int ch = 0; ch < NUART; ch++) begin
			c = rand_cmd(OP_WRITE);
			c.channel = CH_BITS'(ch);
			run_cmd(c, F_NONE);
			c = rand_cmd(OP_READ);
			c.channel = CH_BITS'(ch);
			run_cmd(c, F_NONE);
		end

		repeat (4) @(negedge clk);
		if (n_rsp != n_cmd || exp_rsp_q.size() != 0 || exp_frame_q.size() != 0) begin
			$display("Got %0d responses for %0d commands, %0d frames never seen",
				n_rsp, n_cmd, exp_frame_q.size());
			rsp_errs++;
		end
		$display("Errors: response %0d, frame %0d, line %0d", rsp_errs, frame_errs, line_errs);
		if (rsp_errs + frame_errs + line_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- src.f
source/tmc_pkg.sv
source/uart_byte.sv
source/tmc_crc8.sv
source/tmc_uart_master.sv
source/tmc_uart_top.sv
test/tmc_uart_chk.sv
test/tb_tmc_uart.sv

//--- run.sh
#!/bin/bash
# Build with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_tmc_uart -f src.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
